// File: filelist.f
hdl/tse_rx_pkg.sv
hdl/hdr_word_parser.sv
hdl/pkt_bufid_pool.sv
hdl/descriptor_send.sv
hdl/tse_rx_top.sv
tb/tb_tse_rx.sv

// File: Bender.yml
package:
  name: tse_rx

dependencies: {}

sources:
  # design, package first
  - files:
      - hdl/tse_rx_pkg.sv
      - hdl/hdr_word_parser.sv
      - hdl/pkt_bufid_pool.sv
      - hdl/descriptor_send.sv
      - hdl/tse_rx_top.sv

  # testbench
  - target: test
    files:
      - tb/tb_tse_rx.sv

// File: tb/tb_tse_rx.sv
// tse rx testbench, random header frames checked against a pool and routing model
`timescale 1ns/1ps

module tb_tse_rx;
    import tse_rx_pkg::*;

    localparam int POOL_DEPTH = 4;
    localparam int TX_DELAY   = 16;
    localparam int CYC_LIMIT  = 40 * 60 + POOL_DEPTH + 16;

    logic               i_clk;
    logic               i_rst_n;
    hdr_word_t          i_hdr;
    logic               i_hdr_valid;
    logic [3:0]         i_inport;
    logic               i_free_wr;
    logic [BUFID_W-1:0] i_free_bufid;
    desc_t              o_desc;
    dest_e              o_desc_wr;
    logic               o_inv_map_flag;
    logic               i_desc_ack;
    send_state_e        o_state;
    logic [15:0]        o_drop_cnt;

    integer             seed = 55555;
    int                 cyc = 0;
    int                 test_err = 0;
    int                 errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    logic [BUFID_W-1:0] pool_q[$];
    logic [15:0]        words[$];
    desc_body_t         exp_body;
    logic [15:0]        exp_type;

    tse_rx_top #(
        .POOL_DEPTH (POOL_DEPTH),
        .FROM_SRC   (SRC_SCP),
        .TX_DELAY   (TX_DELAY)
    ) dut (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_hdr          (i_hdr),
        .i_hdr_valid    (i_hdr_valid),
        .i_inport       (i_inport),
        .i_free_wr      (i_free_wr),
        .i_free_bufid   (i_free_bufid),
        .o_desc         (o_desc),
        .o_desc_wr      (o_desc_wr),
        .o_inv_map_flag (o_inv_map_flag),
        .i_desc_ack     (i_desc_ack),
        .o_state        (o_state),
        .o_drop_cnt     (o_drop_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYC_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reporting and random helpers
    ////////////////////////////////////////////////////////////

    task automatic value_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        test_err++;
    endtask

    task automatic missing_event(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        test_err++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_err;
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_err);
            tests_failed++;
        end
        test_err = 0;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    function automatic logic [15:0] pick_type();
        logic [15:0] t;
        case (rand_range(0, 5))
            0: t = ETH_TSN_CTRL;
            1: t = ETH_PTP;
            2: t = ETH_TSMP;
            3: t = ETH_INV_MAP;
            default: begin
                t = 16'($random(seed));
                // an untagged frame must not look tagged
                if (t == ETH_VLAN) begin
                    t = 16'h0800;
                end
            end
        endcase
        return t;
    endfunction

    // scp-side port, so network class goes to the hcp
    function automatic dest_e model_dest(input logic [15:0] t);
        if (t == ETH_TSN_CTRL || t == ETH_PTP || t == ETH_TSMP) begin
            return HCP;
        end
        return HOST;
    endfunction

    ////////////////////////////////////////////////////////////
    // frame stimulus
    ////////////////////////////////////////////////////////////

    task automatic build_frame(input logic has_tag, input logic [15:0] etype, input int len);
        logic [15:0] w;
        words.delete();
        for (int i = 0; i < len; i++) begin
            w = 16'($random(seed));
            if (i == 6) begin
                w = has_tag ? ETH_VLAN : etype;
            end else if (i == 8 && has_tag) begin
                w = etype;
            end
            words.push_back(w);
        end
        exp_type           = etype;
        exp_body.flow_id   = words[2][13:0];
        exp_body.pri       = has_tag ? words[7][15:13] : 3'd0;
        exp_body.inport    = 4'($random(seed));
        exp_body.frame_len = (2 * len > 1023) ? 10'h3ff : 10'(2 * len);
    endtask

    task automatic random_frame();
        logic has_tag;
        has_tag = rand_range(0, 1);
        build_frame(has_tag, pick_type(), rand_range(has_tag ? 9 : 7, 20));
    endtask

    // last_c is the cycle in which the last word was taken
    task automatic drive_frame(output int last_c);
        for (int i = 0; i < words.size(); i++) begin
            @(posedge i_clk);
            i_hdr_valid <= 1'b1;
            i_hdr.data  <= words[i];
            i_hdr.first <= (i == 0);
            i_hdr.last  <= (i == words.size() - 1);
            i_inport    <= exp_body.inport;
        end
        @(posedge i_clk);
        i_hdr_valid <= 1'b0;
        i_hdr       <= '0;
        @(negedge i_clk);
        last_c = cyc;
    endtask

    task automatic release_id(input logic [BUFID_W-1:0] id);
        @(posedge i_clk);
        i_free_wr    <= 1'b1;
        i_free_bufid <= id;
        @(posedge i_clk);
        i_free_wr    <= 1'b0;
        pool_q.push_back(id);
        @(negedge i_clk);
    endtask

    ////////////////////////////////////////////////////////////
    // response checks
    ////////////////////////////////////////////////////////////

    task automatic expect_write(input int last_c, input logic [BUFID_W-1:0] id);
        desc_t exp;
        dest_e dest;
        logic  inv;
        int    waited;
        exp.bufid = id;
        exp.body  = exp_body;
        dest      = model_dest(exp_type);
        inv       = (exp_type == ETH_INV_MAP);
        waited    = 0;
        while (o_desc_wr == NONE && waited < 3 * TX_DELAY) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_desc_wr == NONE) begin
            missing_event("no descriptor write appeared after the frame");
            return;
        end
        if (cyc - last_c != 2 + TX_DELAY) begin
            value_error($sformatf("write came %0d cycles after the last word, expected %0d",
                                  cyc - last_c, 2 + TX_DELAY));
        end
        if (o_desc !== exp) begin
            value_error($sformatf("descriptor %h, expected %h", o_desc, exp));
        end
        if (o_desc_wr !== dest) begin
            value_error($sformatf("destination %s, expected %s", o_desc_wr.name(), dest.name()));
        end
        if (o_inv_map_flag !== inv) begin
            value_error($sformatf("inverse map flag %b, expected %b", o_inv_map_flag, inv));
        end
        if (o_state !== ST_WAIT_ACK) begin
            value_error($sformatf("state %s while the write is held", o_state.name()));
        end
        // downstream answers after a random wait
        repeat (rand_range(0, 5)) begin
            @(negedge i_clk);
            if (o_desc !== exp || o_desc_wr !== dest || o_inv_map_flag !== inv) begin
                value_error("descriptor write not held until ack");
            end
        end
        @(posedge i_clk);
        i_desc_ack <= 1'b1;
        @(posedge i_clk);
        i_desc_ack <= 1'b0;
        @(negedge i_clk);
        if (o_desc_wr !== NONE || o_inv_map_flag !== 1'b0 || o_state !== ST_IDLE) begin
            value_error("write, inverse map flag or state not cleared after ack");
        end
    endtask

    task automatic run_frame(input logic free_after);
        int                 last_c;
        logic [BUFID_W-1:0] id;
        drive_frame(last_c);
        id = pool_q.pop_front();
        expect_write(last_c, id);
        if (free_after) begin
            release_id(id);
        end
    endtask

    task automatic expect_drop(input int prev);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 2 * TX_DELAY; i++) begin
            @(negedge i_clk);
            if (o_desc_wr !== NONE && !seen) begin
                value_error("descriptor written for a frame that should be dropped");
                seen = 1'b1;
            end
        end
        if (o_drop_cnt !== 16'(prev + 1)) begin
            value_error($sformatf("drop count %0d, expected %0d", o_drop_cnt, prev + 1));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          drop0;
        int          last_a;
        int          last_b;
        desc_body_t  body_a;
        logic [15:0] type_a;
        send_state_e st_b;
        logic [BUFID_W-1:0] id;
        i_rst_n      = 1'b0;
        i_hdr        = '0;
        i_hdr_valid  = 1'b0;
        i_inport     = '0;
        i_free_wr    = 1'b0;
        i_free_bufid = '0;
        i_desc_ack   = 1'b0;
        for (int i = 0; i < POOL_DEPTH; i++) begin
            pool_q.push_back(BUFID_W'(i));
        end
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        // pool loads its ids one per cycle
        repeat (POOL_DEPTH + 2) @(posedge i_clk);
        @(negedge i_clk);
        if (o_desc_wr !== NONE || o_drop_cnt !== 16'd0 || o_state !== ST_IDLE) begin
            value_error("outputs not idle after reset");
        end

        repeat (20) begin
            random_frame();
            run_frame(1'b1);
        end
        end_test("routing and packing");

        build_frame(1'b1, ETH_INV_MAP, rand_range(9, 20));
        run_frame(1'b1);
        build_frame(1'b0, ETH_INV_MAP, rand_range(7, 20));
        run_frame(1'b1);
        build_frame(1'b0, ETH_PTP, rand_range(7, 20));
        run_frame(1'b1);
        end_test("inverse map flag");

        repeat (4) begin
            random_frame();
            run_frame(1'b1);
        end
        end_test("transmit delay");

        // second frame ends while the first is in its delay
        drop0 = o_drop_cnt;
        random_frame();
        drive_frame(last_a);
        body_a = exp_body;
        type_a = exp_type;
        build_frame(1'b0, pick_type(), 8);
        drive_frame(last_b);
        st_b = (model_dest(type_a) == HOST) ? ST_DELAY_HOST : ST_DELAY_NET;
        if (o_state !== st_b) begin
            value_error($sformatf("state %s when the second frame ended, expected %s",
                                  o_state.name(), st_b.name()));
        end
        exp_body = body_a;
        exp_type = type_a;
        id = pool_q.pop_front();
        expect_write(last_a, id);
        release_id(id);
        expect_drop(drop0);
        random_frame();
        run_frame(1'b1);
        end_test("busy drop");

        // ids are not returned, so the fifth frame finds the pool empty
        repeat (POOL_DEPTH) begin
            random_frame();
            run_frame(1'b0);
        end
        drop0 = o_drop_cnt;
        random_frame();
        drive_frame(last_a);
        expect_drop(drop0);
        end_test("pool order and exhaustion");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: hdl/tse_rx_top.sv
// tse rx descriptor path top, parser and buffer pool feeding the descriptor sender
`timescale 1ns/1ps

module tse_rx_top #(
    parameter int                   POOL_DEPTH = 512,
    parameter tse_rx_pkg::src_sel_e FROM_SRC   = tse_rx_pkg::SRC_HCP,
    parameter int                   TX_DELAY   = 16
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  tse_rx_pkg::hdr_word_t          i_hdr,
    input  logic                           i_hdr_valid,
    input  logic [3:0]                     i_inport,
    input  logic                           i_free_wr,
    input  logic [tse_rx_pkg::BUFID_W-1:0] i_free_bufid,
    output tse_rx_pkg::desc_t              o_desc,
    output tse_rx_pkg::dest_e              o_desc_wr,
    output logic                           o_inv_map_flag,
    input  logic                           i_desc_ack,
    output tse_rx_pkg::send_state_e        o_state,
    output logic [15:0]                    o_drop_cnt
);
    import tse_rx_pkg::*;

    logic               desc_valid;
    desc_body_t         desc_body;
    logic [15:0]        eth_type;
    logic               bufid_wr;
    logic [BUFID_W-1:0] bufid;
    logic               bufid_ack;

    hdr_word_parser u_parser (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_hdr        (i_hdr),
        .i_hdr_valid  (i_hdr_valid),
        .i_inport     (i_inport),
        .o_desc_valid (desc_valid),
        .o_desc_body  (desc_body),
        .o_eth_type   (eth_type)
    );

    pkt_bufid_pool #(
        .POOL_DEPTH (POOL_DEPTH)
    ) u_pool (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_bufid_wr   (bufid_wr),
        .o_bufid      (bufid),
        .i_bufid_ack  (bufid_ack),
        .i_free_wr    (i_free_wr),
        .i_free_bufid (i_free_bufid)
    );

    descriptor_send #(
        .FROM_SRC (FROM_SRC),
        .TX_DELAY (TX_DELAY)
    ) u_send (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_desc_valid   (desc_valid),
        .i_desc_body    (desc_body),
        .i_eth_type     (eth_type),
        .i_bufid_wr     (bufid_wr),
        .i_bufid        (bufid),
        .o_bufid_ack    (bufid_ack),
        .o_desc         (o_desc),
        .o_desc_wr      (o_desc_wr),
        .o_inv_map_flag (o_inv_map_flag),
        .i_desc_ack     (i_desc_ack),
        .o_state        (o_state),
        .o_drop_cnt     (o_drop_cnt)
    );

endmodule

// File: hdl/descriptor_send.sv
// descriptor sender, joins body and buffer id, delays, routes and holds until ack
`timescale 1ns/1ps

module descriptor_send #(
    parameter tse_rx_pkg::src_sel_e FROM_SRC = tse_rx_pkg::SRC_HCP,
    parameter int                   TX_DELAY = 16
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_desc_valid,
    input  tse_rx_pkg::desc_body_t         i_desc_body,
    input  logic [15:0]                    i_eth_type,
    input  logic                           i_bufid_wr,
    input  logic [tse_rx_pkg::BUFID_W-1:0] i_bufid,
    output logic                           o_bufid_ack,
    output tse_rx_pkg::desc_t              o_desc,
    output tse_rx_pkg::dest_e              o_desc_wr,
    output logic                           o_inv_map_flag,
    input  logic                           i_desc_ack,
    output tse_rx_pkg::send_state_e        o_state,
    output logic [15:0]                    o_drop_cnt
);
    import tse_rx_pkg::*;

    localparam int DLY_W = (TX_DELAY > 0) ? $clog2(TX_DELAY + 1) : 1;
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(TX_DELAY);
    // network class goes to the processor on the other side
    localparam dest_e NET_DEST = (FROM_SRC == SRC_HCP) ? NET : HCP;

    send_state_e      state;
    logic [DLY_W-1:0] dly_cnt;
    logic             accept;
    logic             net_type;
    logic             inv_type;

    if (DESC_W != $bits(desc_t)) begin : g_width_check
        $error("descriptor struct width differs from DESC_W");
    end

    assign accept   = (state == ST_IDLE) && i_desc_valid && i_bufid_wr;
    assign net_type = i_eth_type inside {ETH_TSN_CTRL, ETH_PTP, ETH_TSMP};
    assign inv_type = (i_eth_type == ETH_INV_MAP);
    assign o_state  = state;

    ////////////////////////////////////////////////////////////
    // send fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state          <= ST_IDLE;
            dly_cnt        <= '0;
            o_bufid_ack    <= 1'b0;
            o_desc_wr      <= NONE;
            o_inv_map_flag <= 1'b0;
            o_drop_cnt     <= '0;
        end else begin
            // pops the pool head one cycle after accept
            o_bufid_ack <= accept;
            // busy or no free id
            if (i_desc_valid && !accept) begin
                o_drop_cnt <= o_drop_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    dly_cnt <= '0;
                    if (accept) begin
                        o_inv_map_flag <= inv_type;
                        state          <= net_type ? ST_DELAY_NET : ST_DELAY_HOST;
                    end
                end
                ST_DELAY_HOST, ST_DELAY_NET: begin
                    if (dly_cnt == DLY_LAST) begin
                        o_desc_wr <= (state == ST_DELAY_NET) ? NET_DEST : HOST;
                        state     <= ST_WAIT_ACK;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                ST_WAIT_ACK: begin
                    if (i_desc_ack) begin
                        o_desc_wr      <= NONE;
                        o_inv_map_flag <= 1'b0;
                        state          <= ST_IDLE;
                    end
                end
                default: begin
                    o_desc_wr <= NONE;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

    // descriptor payload, kept until the next accept
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_desc.bufid <= i_bufid;
            o_desc.body  <= i_desc_body;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // one pop per accepted descriptor
    a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_bufid_ack |=> !o_bufid_ack);

    // write held steady toward the destination until acknowledged
    a_desc_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((o_desc_wr != NONE) && !i_desc_ack) |=>
            ($stable(o_desc) && (o_desc_wr == $past(o_desc_wr))));

endmodule

// File: hdl/pkt_bufid_pool.sv
// packet buffer id pool, circular free list filled with sequential ids after reset
`timescale 1ns/1ps

module pkt_bufid_pool #(
    parameter int POOL_DEPTH = 512
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    output logic                           o_bufid_wr,
    output logic [tse_rx_pkg::BUFID_W-1:0] o_bufid,
    input  logic                           i_bufid_ack,
    input  logic                           i_free_wr,
    input  logic [tse_rx_pkg::BUFID_W-1:0] i_free_bufid
);
    import tse_rx_pkg::*;

    localparam int PTR_W = (POOL_DEPTH > 1) ? $clog2(POOL_DEPTH) : 1;
    localparam int CNT_W = $clog2(POOL_DEPTH + 1);
    localparam logic [PTR_W-1:0]   LAST_PTR = PTR_W'(POOL_DEPTH - 1);
    localparam logic [CNT_W-1:0]   FULL_CNT = CNT_W'(POOL_DEPTH);
    localparam logic [BUFID_W-1:0] LAST_ID  = BUFID_W'(POOL_DEPTH - 1);

    logic [BUFID_W-1:0] id_mem [POOL_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               filling;
    logic [BUFID_W-1:0] fill_id;
    logic               pop;
    logic               push;
    logic               wr_en;
    logic [BUFID_W-1:0] wr_data;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign pop     = i_bufid_ack && o_bufid_wr;
    assign push    = i_free_wr && !filling;
    // fill and release share the write port
    assign wr_en   = filling || push;
    assign wr_data = filling ? fill_id : i_free_bufid;

    assign o_bufid_wr = !filling && (count != '0);
    assign o_bufid    = id_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // pointers and fill level
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            filling <= 1'b1;
            fill_id <= '0;
        end else begin
            if (filling) begin
                fill_id <= fill_id + 1'b1;
                if (fill_id == LAST_ID) begin
                    filling <= 1'b0;
                end
            end
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            id_mem[wr_ptr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // sender only pops when a head id is offered
    a_no_ack_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_bufid_ack |-> o_bufid_wr);

    // more releases than ids handed out
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_free_wr |-> ((count != FULL_CNT) || pop));

endmodule

// File: hdl/hdr_word_parser.sv
// header word parser, turns a 16-bit header stream into a descriptor body and type
`timescale 1ns/1ps

module hdr_word_parser (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  tse_rx_pkg::hdr_word_t  i_hdr,
    input  logic                   i_hdr_valid,
    input  logic [3:0]             i_inport,
    output logic                   o_desc_valid,
    output tse_rx_pkg::desc_body_t o_desc_body,
    output logic [15:0]            o_eth_type
);
    import tse_rx_pkg::*;

    localparam int CNT_W = 10;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] word_idx;
    logic [CNT_W-1:0] word_num;
    logic             vlan_seen;
    logic             type_seen;
    logic             type_here;
    logic             vlan_here;
    logic             type_done;

    // index of the current beat, first word restarts the count
    assign word_idx = i_hdr.first ? '0 : word_cnt;
    assign word_num = (word_idx == CNT_MAX) ? CNT_MAX : word_idx + 1'b1;

    assign vlan_here = (word_idx == 6) && (i_hdr.data == ETH_VLAN);
    // type sits in word 6, or in word 8 behind a tag
    assign type_here = ((word_idx == 6) && (i_hdr.data != ETH_VLAN)) ||
                       ((word_idx == 8) && vlan_seen);
    assign type_done = (type_seen && !i_hdr.first) || type_here;

    ////////////////////////////////////////////////////////////
    // frame control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            word_cnt     <= '0;
            vlan_seen    <= 1'b0;
            type_seen    <= 1'b0;
            o_desc_valid <= 1'b0;
        end else begin
            o_desc_valid <= 1'b0;
            if (i_hdr_valid) begin
                word_cnt <= word_num;
                if (i_hdr.first) begin
                    vlan_seen <= 1'b0;
                    type_seen <= 1'b0;
                end
                if (vlan_here) begin
                    vlan_seen <= 1'b1;
                end
                if (type_here) begin
                    type_seen <= 1'b1;
                end
                // short frames without a type word send nothing
                if (i_hdr.last) begin
                    o_desc_valid <= type_done;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // field capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_hdr_valid) begin
            if (i_hdr.first) begin
                o_desc_body.inport <= i_inport;
                o_desc_body.pri    <= '0;
            end
            if (word_idx == 2) begin
                o_desc_body.flow_id <= i_hdr.data[13:0];
            end
            if ((word_idx == 7) && vlan_seen) begin
                o_desc_body.pri <= i_hdr.data[15:13];
            end
            if (type_here) begin
                o_eth_type <= i_hdr.data;
            end
            if (i_hdr.last) begin
                o_desc_body.frame_len <= word_num[CNT_W-1] ? 10'h3ff
                                                           : {word_num[8:0], 1'b0};
            end
        end
    end

endmodule

// File: hdl/tse_rx_pkg.sv
// tse rx descriptor path, shared widths, descriptor layout and enums

package tse_rx_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int BUFID_W = 9;
    localparam int DESC_W  = 40;

    ////////////////////////////////////////////////////////////
    // descriptor layout
    ////////////////////////////////////////////////////////////

    // 31-bit body, produced by the header parser
    typedef struct packed {
        logic [13:0] flow_id;    // low bits of destination mac
        logic [2:0]  pri;        // vlan priority, zero when untagged
        logic [3:0]  inport;
        logic [9:0]  frame_len;  // header words times two, saturating
    } desc_body_t;

    // full descriptor, buffer id on top
    typedef struct packed {
        logic [BUFID_W-1:0] bufid;
        desc_body_t         body;
    } desc_t;

    // one header beat
    typedef struct packed {
        logic [15:0] data;
        logic        first;
        logic        last;
    } hdr_word_t;

    ////////////////////////////////////////////////////////////
    // ethernet types
    ////////////////////////////////////////////////////////////

    // network class
    localparam logic [15:0] ETH_TSN_CTRL = 16'h891d;
    localparam logic [15:0] ETH_PTP      = 16'h88f7;
    localparam logic [15:0] ETH_TSMP     = 16'hff01;

    localparam logic [15:0] ETH_INV_MAP  = 16'h1800;
    localparam logic [15:0] ETH_VLAN     = 16'h8100;

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////

    // processor served by this port
    typedef enum logic {
        SRC_HCP,
        SRC_SCP
    } src_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DELAY_HOST,
        ST_DELAY_NET,
        ST_WAIT_ACK
    } send_state_e;

    typedef enum logic [1:0] {
        NONE,
        HOST,
        HCP,
        NET
    } dest_e;

endpackage
